/* design/bbox_pkg.sv */
package bbox_pkg;

    // Fixed-point format shared by every coordinate in the stage
    // Total bits per coordinate, two's complement
    localparam int SIGFIG = 24;
    // Fraction bits below the binary point
    localparam int RADIX = 10;
    // Integer bits above the binary point, sign included
    localparam int INT_BITS = SIGFIG - RADIX;

    // Register stages between the sampled input and the output
    localparam int PIPE_DEPTH = 3;

    // Signed fixed-point coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One point in screen space
    // Also used for box corners and for the screen size
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Three vertices of one triangle
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Axis-aligned box
    // ll holds the minima, ur the maxima
    typedef struct packed {
        vertex_t ll;
        vertex_t ur;
    } box_t;

    // Samples per pixel, one-hot
    // Grid spacing is 1, 1/2, 1/4 and 1/8 pixel in that order
    typedef enum logic [3:0] {
        MSAA_1  = 4'b1000,
        MSAA_4  = 4'b0100,
        MSAA_16 = 4'b0010,
        MSAA_64 = 4'b0001
    } msaa_e;

    // Unit carried down the pipeline and presented at the output
    // valid low means the box is not meaningful
    typedef struct packed {
        logic      valid;
        triangle_t triangle;
        box_t      box;
    } bbox_item_t;

endpackage

/* design/bbox_extent.sv */
module bbox_extent import bbox_pkg::*; (
    input  triangle_t triangle,
    output box_t      box
);

    // One-hot pick of the smallest of three values
    // Ties resolve to the lowest-numbered vertex
    function automatic logic [2:0] min_sel(coord_t a, coord_t b, coord_t c);
        logic [2:0] sel;
        sel[0] = (a <= b) && (a <= c);
        sel[1] = (a > b) && (b <= c);
        sel[2] = (a > c) && (b > c);
        return sel;
    endfunction

    // One-hot pick of the largest of three values
    // Ties again favour the lowest-numbered vertex
    function automatic logic [2:0] max_sel(coord_t a, coord_t b, coord_t c);
        logic [2:0] sel;
        sel[0] = (a >= b) && (a >= c);
        sel[1] = (a < b) && (b >= c);
        sel[2] = (a < c) && (b < c);
        return sel;
    endfunction

    // AND-OR mux driven by a one-hot select
    function automatic coord_t pick(logic [2:0] sel, coord_t a, coord_t b, coord_t c);
        coord_t res;
        res = ({SIGFIG{sel[0]}} & a)
            | ({SIGFIG{sel[1]}} & b)
            | ({SIGFIG{sel[2]}} & c);
        return res;
    endfunction

    // Vertex coordinates pulled out as signed values
    coord_t x0, x1, x2;
    coord_t y0, y1, y2;

    // Selects per axis
    logic [2:0] min_sel_x;
    logic [2:0] max_sel_x;
    logic [2:0] min_sel_y;
    logic [2:0] max_sel_y;

    assign x0 = triangle.v0.x;
    assign x1 = triangle.v1.x;
    assign x2 = triangle.v2.x;
    assign y0 = triangle.v0.y;
    assign y1 = triangle.v1.y;
    assign y2 = triangle.v2.y;

    always_comb begin
        // Pairwise signed compares on each axis
        min_sel_x = min_sel(x0, x1, x2);
        max_sel_x = max_sel(x0, x1, x2);
        min_sel_y = min_sel(y0, y1, y2);
        max_sel_y = max_sel(y0, y1, y2);

        // Lower left gets the minima
        box.ll.x = pick(min_sel_x, x0, x1, x2);
        box.ll.y = pick(min_sel_y, y0, y1, y2);
        // Upper right gets the maxima, so ll never passes ur
        box.ur.x = pick(max_sel_x, x0, x1, x2);
        box.ur.y = pick(max_sel_y, y0, y1, y2);
    end

endmodule

/* design/bbox_snap_clip.sv */
module bbox_snap_clip import bbox_pkg::*; (
    input  box_t    box,
    input  logic    tri_valid,
    input  vertex_t screen,
    input  msaa_e   msaa,
    output box_t    clipped,
    output logic    valid
);

    // Fraction bits kept by the current sample grid
    logic [RADIX-1:0] frac_mask;
    // Full-width mask, integer part always kept
    coord_t grid_mask;

    // Corners after flooring to the grid
    coord_t snap_ll_x;
    coord_t snap_ll_y;
    coord_t snap_ur_x;
    coord_t snap_ur_y;

    // Screen size as signed values
    coord_t scr_x;
    coord_t scr_y;

    // Per-edge overlap tests on the snapped box
    logic right_of_left;
    logic above_bottom;
    logic left_of_right;
    logic below_top;

    assign scr_x = screen.x;
    assign scr_y = screen.y;

    // Grid spacing to mask
    // 1x keeps no fraction bits, each step up keeps one more
    always_comb begin
        case (msaa)
            MSAA_1: begin
                frac_mask = '0;
            end
            MSAA_4: begin
                frac_mask = {1'b1, {(RADIX-1){1'b0}}};
            end
            MSAA_16: begin
                frac_mask = {2'b11, {(RADIX-2){1'b0}}};
            end
            MSAA_64: begin
                frac_mask = {3'b111, {(RADIX-3){1'b0}}};
            end
            default: begin
                // Unknown code behaves like one sample per pixel
                frac_mask = '0;
            end
        endcase
    end

    assign grid_mask = {{INT_BITS{1'b1}}, frac_mask};

    // Clearing low bits of a two's complement value floors it,
    // negative coordinates included
    always_comb begin
        snap_ll_x = box.ll.x & grid_mask;
        snap_ll_y = box.ll.y & grid_mask;
        snap_ur_x = box.ur.x & grid_mask;
        snap_ur_y = box.ur.y & grid_mask;
    end

    // Clamp to the screen rectangle with origin at lower left
    always_comb begin
        // Lower left cannot go below zero
        if (snap_ll_x < 0) begin
            clipped.ll.x = '0;
        end else begin
            clipped.ll.x = snap_ll_x;
        end
        if (snap_ll_y < 0) begin
            clipped.ll.y = '0;
        end else begin
            clipped.ll.y = snap_ll_y;
        end

        // Upper right cannot go past the screen size
        if (snap_ur_x > scr_x) begin
            clipped.ur.x = scr_x;
        end else begin
            clipped.ur.x = snap_ur_x;
        end
        if (snap_ur_y > scr_y) begin
            clipped.ur.y = scr_y;
        end else begin
            clipped.ur.y = snap_ur_y;
        end
    end

    // Rejection uses the unclamped snapped box
    // Clamped values would always look on screen
    assign right_of_left = (snap_ur_x >= 0);
    assign above_bottom  = (snap_ur_y >= 0);
    assign left_of_right = (snap_ll_x <= scr_x);
    assign below_top     = (snap_ll_y <= scr_y);

    // Box must touch the screen on both axes
    assign valid = tri_valid
                && right_of_left
                && above_bottom
                && left_of_right
                && below_top;

endmodule

/* design/bbox_pipe.sv */
module bbox_pipe import bbox_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       halt,
    input  bbox_item_t in,
    output bbox_item_t out
);

    // Stage 0 takes the input, last stage drives the output
    bbox_item_t stage [PIPE_DEPTH];

    // All stages move together or all hold
    always_ff @(posedge clk) begin
        if (reset) begin
            // Only the valid bits are cleared
            // Payload keeps whatever it had
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else if (!halt) begin
            stage[0] <= in;
            // Shift toward the output
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
        // halt high, everything keeps its value
    end

    // Output straight from the last register, stable while halted
    assign out = stage[PIPE_DEPTH-1];

endmodule

/* design/bbox_top.sv */
module bbox_top import bbox_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  triangle_t  triangle,
    input  logic       tri_valid,
    input  vertex_t    screen,
    input  msaa_e      msaa,
    input  logic       halt,
    output bbox_item_t out
);

    // Unsnapped extent of the incoming triangle
    box_t raw_box;
    // Snapped and clamped box
    box_t clipped_box;
    // Triangle valid and on screen
    logic box_valid;
    // Item entering the first register stage
    bbox_item_t pipe_in;

    // Min and max of the three vertices
    bbox_extent u_extent (
        .triangle (triangle),
        .box      (raw_box)
    );

    // Grid floor, screen clamp and reject
    // Screen and msaa are static while triangles are in flight
    bbox_snap_clip u_snap_clip (
        .box       (raw_box),
        .tri_valid (tri_valid),
        .screen    (screen),
        .msaa      (msaa),
        .clipped   (clipped_box),
        .valid     (box_valid)
    );

    // Triangle rides along with its box
    assign pipe_in.valid    = box_valid;
    assign pipe_in.triangle = triangle;
    assign pipe_in.box      = clipped_box;

    // Everything above is combinational
    // Latency is set by the register stages here
    bbox_pipe u_pipe (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .in    (pipe_in),
        .out   (out)
    );

endmodule

/* sim/bbox_model.svh */
`ifndef BBOX_MODEL_SVH
`define BBOX_MODEL_SVH

// Sign-extend a fixed-point coordinate to a plain int
function automatic int to_int(coord_t c);
    return int'(c);
endfunction

// Sample grid spacing in fixed-point units
// One pixel is 1 << RADIX
function automatic int grid_step(msaa_e mode);
    case (mode)
        MSAA_4: return 1 << (RADIX - 1);
        MSAA_16: return 1 << (RADIX - 2);
        MSAA_64: return 1 << (RADIX - 3);
        default: return 1 << RADIX;
    endcase
endfunction

// Round toward minus infinity onto a multiple of step
function automatic int floor_to_grid(int v, int step);
    if (v >= 0) begin
        return (v / step) * step;
    end
    return -(((-v) + step - 1) / step) * step;
endfunction

function automatic int min3(int a, int b, int c);
    int m;
    m = a;
    if (b < m) begin
        m = b;
    end
    if (c < m) begin
        m = c;
    end
    return m;
endfunction

function automatic int max3(int a, int b, int c);
    int m;
    m = a;
    if (b > m) begin
        m = b;
    end
    if (c > m) begin
        m = c;
    end
    return m;
endfunction

// Expected pipeline item for one sampled triangle
function automatic bbox_item_t expected_item(triangle_t t, logic tv, vertex_t scr, msaa_e mode);
    int step;
    int lx;
    int ly;
    int ux;
    int uy;
    int sx;
    int sy;
    bbox_item_t item;
    step = grid_step(mode);
    sx = to_int(scr.x);
    sy = to_int(scr.y);
    // Extent first, then floor each corner
    lx = floor_to_grid(min3(to_int(t.v0.x), to_int(t.v1.x), to_int(t.v2.x)), step);
    ly = floor_to_grid(min3(to_int(t.v0.y), to_int(t.v1.y), to_int(t.v2.y)), step);
    ux = floor_to_grid(max3(to_int(t.v0.x), to_int(t.v1.x), to_int(t.v2.x)), step);
    uy = floor_to_grid(max3(to_int(t.v0.y), to_int(t.v1.y), to_int(t.v2.y)), step);
    // Overlap with the screen, judged before clamping
    item.valid = tv && (ux >= 0) && (uy >= 0) && (lx <= sx) && (ly <= sy);
    item.triangle = t;
    item.box.ll.x = coord_t'((lx < 0) ? 0 : lx);
    item.box.ll.y = coord_t'((ly < 0) ? 0 : ly);
    item.box.ur.x = coord_t'((ux > sx) ? sx : ux);
    item.box.ur.y = coord_t'((uy > sy) ? sy : uy);
    return item;
endfunction

`endif

/* sim/tb_bbox.sv */
module tb_bbox import bbox_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    `include "bbox_model.svh"

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES = 2000;
    // Each segment runs one msaa mode including its drain
    localparam int SEGMENT_CYCLES = 250;
    localparam int DRAIN_CYCLES = 6;
    // Reset and the last drain fit well inside the margin
    localparam int WATCHDOG_CYCLES = NUM_CYCLES + 200;

    // Screen size in pixels
    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;
    // Triangle centres span -128 to +1200 pixels
    localparam int CENTRE_LO = -128;
    localparam int CENTRE_SPAN = 1328;
    // Vertices land within 32 pixels of the centre with any fraction
    localparam int SPREAD = 64 << RADIX;

    // Model pipeline slot
    // known stays low until a sampled item fills it
    typedef struct packed {
        logic       known;
        bbox_item_t item;
    } model_slot_t;

    logic       clk;
    logic       reset;
    triangle_t  triangle;
    logic       tri_valid;
    vertex_t    screen;
    msaa_e      msaa;
    logic       halt;
    bbox_item_t out;

    // Oldest entry at index 0 lines up with out
    model_slot_t model_q[$];
    bbox_item_t  prev_out;
    // Inputs seen at the most recent rising edge
    logic        edge_halt;
    logic        edge_reset;
    int          error_count;
    int          check_count;

    bbox_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .triangle  (triangle),
        .tri_valid (tri_valid),
        .screen    (screen),
        .msaa      (msaa),
        .halt      (halt),
        .out       (out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic coord_t random_coord(int centre);
        return coord_t'(centre * (1 << RADIX) + int'($urandom_range(0, SPREAD - 1)) - SPREAD / 2);
    endfunction

    // Small triangle around a random centre so that some fall fully off screen
    function automatic triangle_t random_triangle();
        triangle_t t;
        int cx;
        int cy;
        cx = int'($urandom_range(0, CENTRE_SPAN)) + CENTRE_LO;
        cy = int'($urandom_range(0, CENTRE_SPAN)) + CENTRE_LO;
        t.v0.x = random_coord(cx);
        t.v0.y = random_coord(cy);
        t.v1.x = random_coord(cx);
        t.v1.y = random_coord(cy);
        t.v2.x = random_coord(cx);
        t.v2.y = random_coord(cy);
        return t;
    endfunction

    // Modes in order 1, 4, 16, 64 samples per pixel
    function automatic msaa_e mode_for(int seg);
        case (seg % 4)
            1: return MSAA_4;
            2: return MSAA_16;
            3: return MSAA_64;
            default: return MSAA_1;
        endcase
    endfunction

    task automatic report_mismatch(string name, string expected, string actual);
        error_count++;
        $display("Fail %s: expected %s, actual %s", name, expected, actual);
    endtask

    // One stimulus cycle
    // A triangle refused under halt is held for the next cycle
    task automatic drive_random();
        if (!halt) begin
            triangle <= random_triangle();
            tri_valid <= ($urandom_range(0, 99) < 80);
        end
        halt <= ($urandom_range(0, 99) < 25);
    endtask

    // Invalid items with halt low flush every stage
    task automatic drain_pipeline();
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            tri_valid <= 1'b0;
            halt <= 1'b0;
        end
    endtask

    function automatic void reset_model();
        model_slot_t empty_slot;
        empty_slot = '0;
        model_q.delete();
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            model_q.push_back(empty_slot);
        end
    endfunction

    // Model pipeline moves on the same edges as the DUT
    always @(posedge clk) begin
        model_slot_t slot;
        edge_halt = halt;
        edge_reset = reset;
        if (reset) begin
            reset_model();
        end else if (!halt) begin
            slot.known = 1'b1;
            slot.item = expected_item(triangle, tri_valid, screen, msaa);
            model_q.push_back(slot);
            void'(model_q.pop_front());
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        model_slot_t slot;
        string name;
        if (model_q.size() == PIPE_DEPTH) begin
            slot = model_q[0];
            check_count++;
            if (!slot.known) begin
                name = "reset valid";
            end else if (slot.item.valid) begin
                name = "accept valid";
            end else begin
                name = "reject valid";
            end
            if (out.valid !== slot.item.valid) begin
                report_mismatch(name, $sformatf("%b", slot.item.valid),
                                $sformatf("%b", out.valid));
            end else if (slot.item.valid && out.box !== slot.item.box) begin
                report_mismatch($sformatf("box %s", msaa.name()),
                                $sformatf("%h", slot.item.box), $sformatf("%h", out.box));
            end
            // Triangle rides along even when rejected
            if (slot.known && out.triangle !== slot.item.triangle) begin
                report_mismatch("triangle order", $sformatf("%h", slot.item.triangle),
                                $sformatf("%h", out.triangle));
            end
            // Reset beats halt so only a pure halt edge must freeze out
            if (edge_halt && !edge_reset && out !== prev_out) begin
                report_mismatch("halt hold", $sformatf("%h", prev_out), $sformatf("%h", out));
            end
        end
        prev_out = out;
    end

    initial begin
        void'($urandom(4186));
        clk = 1'b0;
        reset = 1'b1;
        // A valid on-screen input during reset must not reach out
        triangle = '0;
        tri_valid = 1'b1;
        screen.x = coord_t'(SCREEN_W << RADIX);
        screen.y = coord_t'(SCREEN_H << RADIX);
        msaa = MSAA_1;
        halt = 1'b0;
        edge_halt = 1'b0;
        edge_reset = 1'b1;
        error_count = 0;
        check_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // msaa only changes once the pipeline holds no valid item
        for (int seg = 0; seg < NUM_CYCLES / SEGMENT_CYCLES; seg++) begin
            drain_pipeline();
            msaa <= mode_for(seg);
            repeat (SEGMENT_CYCLES - DRAIN_CYCLES) begin
                @(posedge clk);
                drive_random();
            end
        end
        drain_pipeline();
        // Let the last edge get checked
        @(negedge clk);
        #1;

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired after %0d clock periods, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+sim
design/bbox_pkg.sv
design/bbox_extent.sv
design/bbox_snap_clip.sv
design/bbox_pipe.sv
design/bbox_top.sv
sim/tb_bbox.sv

/* run.sh */
#!/bin/sh
# Compile and run the bbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_bbox -Mdir obj_dir -o sim_bbox
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_bbox)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
